// ==== common/video_pkg.sv ====
package video_pkg;

  // downsampled frame geometry, same as the tracking stage of the full pipeline
  localparam int HRES = 320;
  localparam int VRES = 180;

  localparam int HCOUNT_W = 9; // 0..319
  localparam int VCOUNT_W = 8; // 0..179

  // rgb565 word as it comes off the camera path
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } pix565_t;

  // one pixel on the stream with its position, 34 bits
  typedef struct packed {
    logic                valid;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    pix565_t             pix;
  } pixel_beat_t;

  // thresholded beat: selected channel plus one mask bit, 27 bits
  typedef struct packed {
    logic                valid;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic [7:0]          channel; // channel value that was compared
    logic                mask;    // 1 when lower <= channel <= upper
  } mask_beat_t;

endpackage

// ==== common/tracker_pkg.sv ====
package tracker_pkg;
  import video_pkg::*;

  // channel picked for thresholding
  typedef enum logic [1:0] {
    CH_RED   = 2'd0,
    CH_GREEN = 2'd1,
    CH_BLUE  = 2'd2,
    CH_LUMA  = 2'd3
  } channel_e;

  // output display mode, code 3 falls back to camera
  typedef enum logic [1:0] {
    DISP_CAMERA = 2'd0,
    DISP_GREY   = 2'd1,
    DISP_MASK   = 2'd2
  } display_e;

  typedef enum logic [1:0] {
    DIV_IDLE     = 2'd0, // waiting for a frame's sums
    DIV_RUN      = 2'd1, // shift-subtract steps
    DIV_ACK_WAIT = 2'd2  // holding ack until req drops
  } div_state_e;

  // accumulator widths, sized for a full 320x180 frame of masked pixels
  localparam int X_SUM_W = 25; // 57600 * 319 < 2^25
  localparam int Y_SUM_W = 24; // 57600 * 179 < 2^24
  localparam int COUNT_W = 16; // 57600 < 2^16

  localparam int MIN_AREA   = 40;      // below this no centre is reported
  localparam int DIV_STEPS  = X_SUM_W; // one quotient bit per step
  localparam int DIV_STEP_W = 5;       // holds 0..DIV_STEPS-1

  typedef struct packed {
    logic [7:0] lower; // inclusive
    logic [7:0] upper; // inclusive
  } threshold_t;

  // per-frame totals handed from accumulator to divider, 65 bits
  typedef struct packed {
    logic [X_SUM_W-1:0] x_sum;
    logic [Y_SUM_W-1:0] y_sum;
    logic [COUNT_W-1:0] count;
  } sums_t;

  typedef struct packed {
    logic [HCOUNT_W-1:0] x;
    logic [VCOUNT_W-1:0] y;
    logic                locked; // set once a first centre has been found
  } com_t;

endpackage

// ==== logic/channel_threshold.sv ====
`timescale 1ns/1ps

module channel_threshold
  import video_pkg::*;
  import tracker_pkg::*;
(
  input  wire         clk_pixel,
  input  wire         recent_reset,
  input  pixel_beat_t pixel_i,
  input  channel_e    channel_sel_i,
  input  threshold_t  thresh_i,
  output mask_beat_t  mask_o,
  output pix565_t     pix_o
);

  logic [7:0] red8, green8, blue8; // colours widened to 8 bits
  logic [9:0] luma_sum;            // r + 2g + b, max 1000
  logic [7:0] luma;
  logic [7:0] chan;                // channel picked by channel_sel_i
  logic       in_range;

  // pad low bits with zeros, no rescaling
  assign red8   = {pixel_i.pix.red, 3'b000};
  assign green8 = {pixel_i.pix.green, 2'b00};
  assign blue8  = {pixel_i.pix.blue, 3'b000};

  assign luma_sum = {2'b00, red8} + {1'b0, green8, 1'b0} + {2'b00, blue8};
  assign luma     = luma_sum[9:2]; // divide by 4, drop remainder

  always_comb begin
    case (channel_sel_i)
      CH_RED:   chan = red8;
      CH_GREEN: chan = green8;
      CH_BLUE:  chan = blue8;
      default:  chan = luma; // CH_LUMA
    endcase
  end

  // both bounds inclusive, an inverted window masks nothing
  assign in_range = (chan >= thresh_i.lower) && (chan <= thresh_i.upper);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      mask_o.valid <= 1'b0;
    end else begin
      mask_o.valid <= pixel_i.valid;
    end
  end

  // payload follows valid, no reset needed
  always_ff @(posedge clk_pixel) begin
    mask_o.hcount  <= pixel_i.hcount;
    mask_o.vcount  <= pixel_i.vcount;
    mask_o.channel <= chan;
    mask_o.mask    <= in_range;
    pix_o          <= pixel_i.pix; // kept aligned with the mask beat for the video mux
  end

endmodule

// ==== com/com_accumulator.sv ====
`timescale 1ns/1ps

module com_accumulator
  import video_pkg::*;
  import tracker_pkg::*;
(
  input  wire        clk_pixel,
  input  wire        recent_reset,
  input  mask_beat_t beat_i,
  output logic       sums_req_o,
  output sums_t      sums_o,
  input  wire        sums_ack_i
);

  logic [X_SUM_W-1:0] x_acc, x_next; // running sums and sums including this beat
  logic [Y_SUM_W-1:0] y_acc, y_next;
  logic [COUNT_W-1:0] cnt_acc, cnt_next;
  logic               hit;           // valid masked pixel
  logic               last_beat;     // bottom-right pixel closes the frame

  assign hit = beat_i.valid && beat_i.mask;

  assign x_next   = x_acc + (hit ? X_SUM_W'(beat_i.hcount) : '0);
  assign y_next   = y_acc + (hit ? Y_SUM_W'(beat_i.vcount) : '0);
  assign cnt_next = cnt_acc + (hit ? COUNT_W'(1) : '0);

  assign last_beat = beat_i.valid
                     && (beat_i.hcount == HCOUNT_W'(HRES - 1))
                     && (beat_i.vcount == VCOUNT_W'(VRES - 1));

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      x_acc      <= '0;
      y_acc      <= '0;
      cnt_acc    <= '0;
      sums_req_o <= 1'b0;
    end else begin
      // requester side: drop req once the divider has latched
      if (sums_req_o && sums_ack_i) begin
        sums_req_o <= 1'b0;
      end

      if (last_beat) begin
        x_acc   <= '0; // next frame starts clean
        y_acc   <= '0;
        cnt_acc <= '0;
        // new req only after the previous ack has fallen, else frame is dropped
        if (!sums_req_o && !sums_ack_i) begin
          sums_req_o <= 1'b1;
        end
      end else begin
        x_acc   <= x_next;
        y_acc   <= y_next;
        cnt_acc <= cnt_next;
      end
    end
  end

  // hand-off register, only loaded when a req is about to rise
  always_ff @(posedge clk_pixel) begin
    if (last_beat && !sums_req_o && !sums_ack_i) begin
      sums_o.x_sum <= x_next;
      sums_o.y_sum <= y_next;
      sums_o.count <= cnt_next;
    end
  end

  // the divider may sample at any point until it acks
  sums_stable_a: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    (sums_req_o && !sums_ack_i) |=> $stable(sums_o));

endmodule

// ==== com/com_divider.sv ====
`timescale 1ns/1ps

module com_divider
  import video_pkg::*;
  import tracker_pkg::*;
(
  input  wire   clk_pixel,
  input  wire   recent_reset,
  input  wire   sums_req_i,
  input  sums_t sums_i,
  output logic  sums_ack_o,
  output com_t  com_o,
  output logic  com_valid_o
);

  // one restoring-division lane: partial remainder and dividend/quotient
  typedef struct packed {
    logic [COUNT_W-1:0] rem;
    logic [X_SUM_W-1:0] dq; // dividend shifts out the top, quotient in the bottom
  } div_lane_t;

  div_state_e           state;
  logic [DIV_STEP_W-1:0] step_cnt; // steps done so far
  logic [COUNT_W-1:0]   divisor;  // masked pixel count
  div_lane_t            x_lane, y_lane;
  div_lane_t            x_next, y_next;

  // one shift-subtract step
  function automatic div_lane_t div_step(input div_lane_t lane,
                                         input logic [COUNT_W-1:0] dvs);
    logic [COUNT_W:0] trial;
    div_lane_t        nxt;
    trial  = {lane.rem, lane.dq[X_SUM_W-1]}; // bring down next dividend bit
    nxt.dq = {lane.dq[X_SUM_W-2:0], 1'b0};
    if (trial >= {1'b0, dvs}) begin
      nxt.rem   = trial[COUNT_W-1:0] - dvs; // result < dvs, fits in COUNT_W
      nxt.dq[0] = 1'b1;
    end else begin
      nxt.rem = trial[COUNT_W-1:0];
    end
    return nxt;
  endfunction

  // both means run in lockstep off the same divisor
  assign x_next = div_step(x_lane, divisor);
  assign y_next = div_step(y_lane, divisor);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      state       <= DIV_IDLE;
      sums_ack_o  <= 1'b0;
      com_o       <= '0;
      com_valid_o <= 1'b0;
      step_cnt    <= '0;
    end else begin
      com_valid_o <= 1'b0; // single-cycle pulse
      case (state)
        DIV_IDLE: begin
          if (sums_req_i) begin
            sums_ack_o <= 1'b1; // sums latched this edge
            step_cnt   <= '0;
            if (sums_i.count >= COUNT_W'(MIN_AREA)) begin
              state <= DIV_RUN;
            end else begin
              state <= DIV_ACK_WAIT; // too small, centre stays as it was
            end
          end
        end
        DIV_RUN: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == DIV_STEP_W'(DIV_STEPS - 1)) begin
            // floor means, the top quotient bits are zero for in-frame sums
            com_o.x      <= x_next.dq[HCOUNT_W-1:0];
            com_o.y      <= y_next.dq[VCOUNT_W-1:0];
            com_o.locked <= 1'b1;
            com_valid_o  <= 1'b1;
            state        <= DIV_ACK_WAIT;
          end
        end
        default: begin // DIV_ACK_WAIT
          if (!sums_req_i) begin
            sums_ack_o <= 1'b0;
            state      <= DIV_IDLE;
          end
        end
      endcase
    end
  end

  // datapath, no reset
  always_ff @(posedge clk_pixel) begin
    if (state == DIV_IDLE && sums_req_i) begin
      divisor   <= sums_i.count;
      x_lane.rem <= '0;
      x_lane.dq  <= sums_i.x_sum;
      y_lane.rem <= '0;
      y_lane.dq  <= X_SUM_W'(sums_i.y_sum);
    end else if (state == DIV_RUN) begin
      x_lane <= x_next;
      y_lane <= y_next;
    end
  end

  // four-phase rule: ack never leads req
  ack_after_req_a: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    $rose(sums_ack_o) |-> sums_req_i);

endmodule

// ==== logic/video_mux.sv ====
`timescale 1ns/1ps

module video_mux
  import video_pkg::*;
  import tracker_pkg::*;
(
  input  wire         clk_pixel,
  input  wire         recent_reset,
  input  mask_beat_t  beat_i,
  input  pix565_t     pix_i,
  input  com_t        com_i,
  input  display_e    display_i,
  input  wire         crosshair_en_i,
  output pixel_beat_t pix_o
);

  pix565_t bg_pix;   // pixel from the display mode
  logic    on_cross; // this position sits on the crosshair

  always_comb begin
    case (display_i)
      DISP_GREY: begin
        // top bits of the channel into each colour field
        bg_pix.red   = beat_i.channel[7:3];
        bg_pix.green = beat_i.channel[7:2];
        bg_pix.blue  = beat_i.channel[7:3];
      end
      DISP_MASK: bg_pix = beat_i.mask ? '1 : '0; // white where masked
      default:   bg_pix = pix_i;                 // camera, also code 3
    endcase
  end

  // only drawn once the divider has produced a centre
  assign on_cross = crosshair_en_i && com_i.locked
                    && ((beat_i.hcount == com_i.x) || (beat_i.vcount == com_i.y));

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      pix_o.valid <= 1'b0;
    end else begin
      pix_o.valid <= beat_i.valid;
    end
  end

  always_ff @(posedge clk_pixel) begin
    pix_o.hcount <= beat_i.hcount;
    pix_o.vcount <= beat_i.vcount;
    pix_o.pix    <= on_cross ? '1 : bg_pix; // crosshair drawn white over any mode
  end

endmodule

// ==== logic/mask_tracker.sv ====
`timescale 1ns/1ps

module mask_tracker
  import video_pkg::*;
  import tracker_pkg::*;
(
  input  wire         clk_pixel,
  input  wire         recent_reset,
  input  pixel_beat_t pixel_i,
  input  channel_e    channel_sel_i,  // quasi-static
  input  threshold_t  thresh_i,       // quasi-static
  input  display_e    display_i,      // quasi-static
  input  wire         crosshair_en_i, // quasi-static
  output mask_beat_t  mask_o,         // pixel_i + 1 cycle
  output pixel_beat_t pix_o,          // pixel_i + 2 cycles
  output com_t        com_o,
  output logic        com_valid_o
);

  mask_beat_t mask_beat; // to accumulator and video mux
  pix565_t    thr_pix;   // camera pixel delayed alongside the mask
  logic       sums_req, sums_ack;
  sums_t      sums;
  com_t       com;

  channel_threshold u_threshold (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .pixel_i       (pixel_i),
    .channel_sel_i (channel_sel_i),
    .thresh_i      (thresh_i),
    .mask_o        (mask_beat),
    .pix_o         (thr_pix)
  );

  com_accumulator u_accumulator (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .beat_i       (mask_beat),
    .sums_req_o   (sums_req),
    .sums_o       (sums),
    .sums_ack_i   (sums_ack)
  );

  com_divider u_divider (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .sums_req_i   (sums_req),
    .sums_i       (sums),
    .sums_ack_o   (sums_ack),
    .com_o        (com),
    .com_valid_o  (com_valid_o)
  );

  video_mux u_video_mux (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .beat_i         (mask_beat),
    .pix_i          (thr_pix),
    .com_i          (com),
    .display_i      (display_i),
    .crosshair_en_i (crosshair_en_i),
    .pix_o          (pix_o)
  );

  assign mask_o = mask_beat;
  assign com_o  = com;

endmodule

// ==== verif/tb_mask_tracker.sv ====
`timescale 1ns/1ps

module tb_mask_tracker
  import video_pkg::*;
  import tracker_pkg::*;
();

  localparam int DRAIN_TIMEOUT = 20;  // cycles for the last beat to leave pix_o
  localparam int COM_TIMEOUT   = 100; // divider needs about DIV_STEPS+3

  logic        clk_pixel = 1'b0;
  logic        recent_reset;
  pixel_beat_t pixel_i;
  channel_e    channel_sel_i;
  threshold_t  thresh_i;
  display_e    display_i;
  logic        crosshair_en_i;
  mask_beat_t  mask_o;
  pixel_beat_t pix_o;
  com_t        com_o;
  logic        com_valid_o;

  // configuration and scene of the current golden line
  int          cfg_chan, cfg_lower, cfg_upper, cfg_disp, cfg_xhair;
  logic [15:0] bg_col, rect_col;
  int          rx0, ry0, rx1, ry1;
  int          exp_x, exp_y; // centre the DUT should currently hold
  logic        exp_locked;

  int          error_count, test_count, test_fail_count;
  int          mask_count, com_pulses;
  logic        monitor_on, last_out_seen;
  logic [15:0] lfsr_state;
  pixel_beat_t d1, d2; // inputs as driven one and two cycles back

  always #2 clk_pixel = ~clk_pixel; // 4 ns period

  mask_tracker UUT (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .pixel_i        (pixel_i),
    .channel_sel_i  (channel_sel_i),
    .thresh_i       (thresh_i),
    .display_i      (display_i),
    .crosshair_en_i (crosshair_en_i),
    .mask_o         (mask_o),
    .pix_o          (pix_o),
    .com_o          (com_o),
    .com_valid_o    (com_valid_o)
  );

  // 16-bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state); // one step per bit
      val = (val << 1) | int'(lfsr_state[0]);
    end
    return val;
  endfunction

  function automatic logic [15:0] scene_pix(input int h, input int v);
    if (h >= rx0 && h <= rx1 && v >= ry0 && v <= ry1) begin
      return rect_col;
    end
    return bg_col;
  endfunction

  // zero-padded colour channel or luma (r + 2g + b) / 4
  function automatic logic [7:0] chan_of(input pix565_t p);
    int r8, g8, b8;
    r8 = int'(p.red) * 8;
    g8 = int'(p.green) * 4;
    b8 = int'(p.blue) * 8;
    case (cfg_chan)
      0:       return 8'(r8);
      1:       return 8'(g8);
      2:       return 8'(b8);
      default: return 8'((r8 + 2 * g8 + b8) / 4);
    endcase
  endfunction

  function automatic logic mask_of(input logic [7:0] ch);
    return (int'(ch) >= cfg_lower) && (int'(ch) <= cfg_upper); // both bounds inclusive
  endfunction

  function automatic logic on_cross(input int hc, input int vc);
    return cfg_xhair != 0 && exp_locked && (hc == exp_x || vc == exp_y);
  endfunction

  function automatic logic [15:0] pix_expected(input pix565_t p, input int hc, input int vc);
    logic [7:0] ch;
    ch = chan_of(p);
    if (on_cross(hc, vc)) begin
      return 16'hFFFF;
    end
    case (cfg_disp)
      1:       return {ch[7:3], ch[7:2], ch[7:3]}; // grey
      2:       return mask_of(ch) ? 16'hFFFF : 16'h0000;
      default: return p; // camera and code 3
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
      error_count++;
    end
  endtask

  // outputs sampled on the falling edge
  always @(negedge clk_pixel) begin
    logic probe;
    if (monitor_on) begin
      check_value("mask_o.valid", 32'(mask_o.valid), 32'(d1.valid)); // 1 cycle latency
      if (d1.valid) begin
        check_value("mask_o.hcount", 32'(mask_o.hcount), 32'(d1.hcount));
        check_value("mask_o.vcount", 32'(mask_o.vcount), 32'(d1.vcount));
        check_value("mask_o.channel", 32'(mask_o.channel), 32'(chan_of(d1.pix)));
        check_value("mask_o.mask", 32'(mask_o.mask), 32'(mask_of(chan_of(d1.pix))));
        if (mask_o.mask) begin
          mask_count++;
        end
      end
      check_value("pix_o.valid", 32'(pix_o.valid), 32'(d2.valid)); // 2 cycle latency
      if (d2.valid) begin
        probe = take_bits(5) == 0; // about one beat in 32
        if (probe || on_cross(d2.hcount, d2.vcount)) begin
          check_value("pix_o.hcount", 32'(pix_o.hcount), 32'(d2.hcount));
          check_value("pix_o.vcount", 32'(pix_o.vcount), 32'(d2.vcount));
          check_value("pix_o.pix", 32'(pix_o.pix),
                      32'(pix_expected(d2.pix, d2.hcount, d2.vcount)));
        end
        if (d2.hcount == HRES - 1 && d2.vcount == VRES - 1) begin
          last_out_seen = 1'b1;
        end
      end
      if (com_valid_o) begin
        com_pulses++;
      end
    end
    d2 = d1;
    d1 = pixel_i;
  end

  task automatic run_frame_test(input int g_count, input int g_x, input int g_y,
                                input int g_valid);
    int errs_before;
    int pulses_before;
    int waited;
    errs_before = error_count;
    test_count++;
    @(posedge clk_pixel);
    channel_sel_i  <= channel_e'(cfg_chan);
    thresh_i       <= '{lower: 8'(cfg_lower), upper: 8'(cfg_upper)};
    display_i      <= display_e'(cfg_disp);
    crosshair_en_i <= (cfg_xhair != 0);
    mask_count    = 0;
    last_out_seen = 1'b0;
    pulses_before = com_pulses;
    for (int v = 0; v < VRES; v++) begin
      for (int h = 0; h < HRES; h++) begin
        @(posedge clk_pixel);
        pixel_i <= '{valid: 1'b1, hcount: HCOUNT_W'(h), vcount: VCOUNT_W'(v),
                     pix: pix565_t'(scene_pix(h, v))};
      end
    end
    @(posedge clk_pixel);
    pixel_i.valid <= 1'b0;
    waited = 0;
    while (!last_out_seen && waited < DRAIN_TIMEOUT) begin
      @(posedge clk_pixel);
      waited++;
    end
    if (!last_out_seen) begin
      $display("timeout: the last pixel of the frame never came out on pix_o");
      error_count++;
    end
    check_value("masked beat count", 32'(mask_count), 32'(g_count));
    waited = 0;
    while (waited < COM_TIMEOUT && !(g_valid != 0 && com_pulses != pulses_before)) begin
      @(posedge clk_pixel);
      waited++;
    end
    if (g_valid != 0) begin
      if (com_pulses == pulses_before) begin
        $display("timeout: no com_valid_o pulse after a frame with enough masked pixels");
        error_count++;
      end
      exp_x      = g_x;
      exp_y      = g_y;
      exp_locked = 1'b1;
    end else begin
      check_value("com_valid_o pulses", 32'(com_pulses - pulses_before), 32'd0);
    end
    check_value("com_o.x", 32'(com_o.x), 32'(g_x));
    check_value("com_o.y", 32'(com_o.y), 32'(g_y));
    check_value("com_o.locked", 32'(com_o.locked), 32'(exp_locked));
    if (error_count == errs_before) begin
      $display("test %0d: pass, %0d masked pixels", test_count, mask_count);
    end else begin
      test_fail_count++;
      $display("test %0d: FAIL, %0d errors", test_count, error_count - errs_before);
    end
  endtask

  initial begin
    int    fd;
    string line;
    int    g_count, g_x, g_y, g_valid;
    error_count     = 0;
    test_count      = 0;
    test_fail_count = 0;
    mask_count      = 0;
    com_pulses      = 0;
    monitor_on      = 1'b0;
    last_out_seen   = 1'b0;
    lfsr_state      = 16'd14;
    exp_x           = 0;
    exp_y           = 0;
    exp_locked      = 1'b0;
    d1              = '0;
    d2              = '0;
    recent_reset    = 1'b1;
    pixel_i         = '0;
    pixel_i.valid   = 1'b1; // valid beats during reset must not reach the outputs
    channel_sel_i   = CH_RED;
    thresh_i        = '0;
    display_i       = DISP_CAMERA;
    crosshair_en_i  = 1'b0;
    repeat (5) @(posedge clk_pixel);
    recent_reset <= 1'b0;
    pixel_i      <= '0;
    @(negedge clk_pixel);
    test_count++;
    check_value("mask_o.valid", 32'(mask_o.valid), 32'd0);
    check_value("pix_o.valid", 32'(pix_o.valid), 32'd0);
    check_value("com_valid_o", 32'(com_valid_o), 32'd0);
    check_value("com_o.locked", 32'(com_o.locked), 32'd0);
    check_value("com_o.x", 32'(com_o.x), 32'd0);
    check_value("com_o.y", 32'(com_o.y), 32'd0);
    if (error_count == 0) begin
      $display("test %0d: reset state ok", test_count);
    end else begin
      test_fail_count++;
      $display("test %0d: FAIL, outputs not cleared by reset", test_count);
    end
    repeat (2) @(posedge clk_pixel); // beats driven during reset leave d1 and d2
    monitor_on = 1'b1;
    fd = $fopen("verif/tracker_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/tracker_golden.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 &&
            $sscanf(line, "%d %d %d %d %d %h %d %d %d %d %h %d %d %d %d",
                    cfg_chan, cfg_lower, cfg_upper, cfg_disp, cfg_xhair, bg_col,
                    rx0, ry0, rx1, ry1, rect_col, g_count, g_x, g_y, g_valid) == 15) begin
          run_frame_test(g_count, g_x, g_y, g_valid);
        end
      end
      $fclose(fd);
    end
    if (test_count < 2) begin
      $display("no test lines were found in the golden file");
      error_count++;
    end
    $display("tests run %0d, tests failed %0d, check failures %0d",
             test_count, test_fail_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verif/tracker_golden.txt ====
# chan(0 r,1 g,2 b,3 luma) lower upper disp(0 cam,1 grey,2 mask,3 cam) crosshair bg(hex565)
# rect x0 y0 x1 y1 (inclusive) colour(hex565) | expected count com_x com_y com_valid
# red square on black, plain camera view
0 200 255 0 0 0000 100 50 109 59 F800 100 104 54 1
# mid green bar on blue, grey view with crosshair
1 100 200 1 1 001F 200 20 219 23 0500 80 209 21 1
# small blue patch below MIN_AREA, centre must hold
2 240 255 2 1 0000 0 0 5 4 001F 30 209 21 0
# white block in the bottom-right corner, luma
3 128 255 0 1 0000 300 170 319 179 FFFF 200 309 174 1
# mid grey at exactly MIN_AREA, single-value luma window, display code 3
3 128 128 3 0 0000 10 100 17 104 8410 40 13 102 1
# dark grey, luma 6 only, mask view with crosshair
3 6 6 2 1 0000 40 60 49 63 0821 40 44 61 1

// ==== mask_tracker.f ====
common/video_pkg.sv
common/tracker_pkg.sv
logic/channel_threshold.sv
com/com_accumulator.sv
com/com_divider.sv
logic/video_mux.sv
logic/mask_tracker.sv
verif/tb_mask_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mask tracker testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f mask_tracker.f \
  --top-module tb_mask_tracker -o tb_mask_tracker > sim.log 2>&1 \
  && ./obj_dir/tb_mask_tracker >> sim.log 2>&1
cat sim.log
grep -q "^Finished with no errors$" sim.log \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
